// File: can_pkg.sv
// shared widths, register index and mode encodings, and bus/frame structs for the CAN wishbone slave
`default_nettype none

package can_pkg;

    localparam int DATA_W    = 32;
    localparam int SEL_W     = 4;
    localparam int ID_W      = 29;
    localparam int DLC_W     = 4;
    localparam int BRP_W     = 10;
    localparam int TS_W      = 3;
    localparam int IDLE_BITS = 11;  // recessive samples before the bus counts as idle
    localparam int NUM_MB    = 3;   // mailboxes covered by reg_idx_e

    // register index, address bits 5:2
    typedef enum logic [3:0] {
        idx_mcr   = 4'd0,  idx_msr   = 4'd1,  idx_tmgr  = 4'd2,
        idx_id0   = 4'd3,  idx_id1   = 4'd4,  idx_id2   = 4'd5,
        idx_size0 = 4'd6,  idx_size1 = 4'd7,  idx_size2 = 4'd8,
        idx_dlo0  = 4'd9,  idx_dlo1  = 4'd10, idx_dlo2  = 4'd11,
        idx_dhi0  = 4'd12, idx_dhi1  = 4'd13, idx_dhi2  = 4'd14,
        idx_none  = 4'd15
    } reg_idx_e;

    typedef enum logic [1:0] {
        mode_sleep  = 2'd0,
        mode_init   = 2'd1,
        mode_normal = 2'd2
    } can_mode_e;

    typedef struct packed {
        logic [DATA_W-6:0] rsvd;
        logic              auto_retrans;
        logic              tx_priority;
        logic              sleep;
        logic              reset;  // self clearing
        logic              start;
    } mcr_t;

    typedef struct packed {
        logic [DATA_W-BRP_W-2*TS_W-1:0] rsvd;
        logic [TS_W-1:0]                ts2;
        logic [TS_W-1:0]                ts1;
        logic [BRP_W-1:0]               brp;
    } tmgr_t;

    typedef struct packed {
        logic            ready;
        logic            ext;
        logic            rtr;
        logic [ID_W-1:0] id;
    } mb_id_t;

    typedef struct packed {
        logic              wr;     // one cycle, first strobe cycle only
        reg_idx_e          idx;
        logic [DATA_W-1:0] wdata;  // already lane masked
        logic [DATA_W-1:0] wmask;
    } bus_req_t;

    typedef struct packed {
        logic [ID_W-1:0]     id;
        logic [DLC_W-1:0]    dlc;
        logic                rtr;
        logic                ext;
        logic [2*DATA_W-1:0] data;
    } tx_frame_t;

    // keep unselected byte lanes of a register
    function automatic logic [DATA_W-1:0] byte_merge(logic [DATA_W-1:0] old_q, bus_req_t req);
        return (old_q & ~req.wmask) | req.wdata;
    endfunction

endpackage

`default_nettype wire

// File: can_wb_port.sv
// wishbone front end: first-strobe detect, delayed ack, lane masking, decode and read return
`timescale 1ns/1ns
`default_nettype none

module can_wb_port (
    input  wire                          wb_clk_i,
    input  wire                          nRST,
    input  wire [can_pkg::DATA_W-1:0]    wb_adr_i,
    input  wire [can_pkg::DATA_W-1:0]    wb_dat_i,
    input  wire [can_pkg::SEL_W-1:0]     wb_sel_i,
    input  wire                          wb_we_i,
    input  wire                          wb_cyc_i,
    input  wire                          wb_stb_i,
    input  wire [can_pkg::DATA_W-1:0]    mode_rdata_i,
    input  wire [can_pkg::DATA_W-1:0]    mb_rdata_i,
    output logic                         wb_ack_o,
    output logic [can_pkg::DATA_W-1:0]   wb_dat_o,
    output can_pkg::bus_req_t            req_o
);

    logic                       valid;
    logic                       first;
    logic [1:0]                 ack_q;
    logic [can_pkg::DATA_W-1:0] lane_mask;

    assign valid = wb_cyc_i & wb_stb_i;
    assign first = valid & ~ack_q[0];  // master idles a cycle between accesses

    always_comb begin
        for (int i = 0; i < can_pkg::SEL_W; i++) begin
            lane_mask[8*i +: 8] = {8{wb_sel_i[i]}};
        end
    end

    ////////////////////////////////////////////////////////////
    // request to the register blocks
    ////////////////////////////////////////////////////////////

    always_comb begin
        req_o.wr    = first & wb_we_i;
        req_o.idx   = can_pkg::reg_idx_e'(wb_adr_i[5:2]);  // base address ignored
        req_o.wdata = wb_dat_i & lane_mask;
        req_o.wmask = lane_mask;
    end

    ////////////////////////////////////////////////////////////
    // ack and read data
    ////////////////////////////////////////////////////////////

    always_ff @(posedge wb_clk_i or negedge nRST) begin
        if (!nRST) begin
            ack_q <= '0;
        end else begin
            ack_q[0] <= valid;
            ack_q[1] <= ack_q[0] & valid;
        end
    end

    assign wb_ack_o = ack_q[1] & valid;

    // blocks return zero for indices that are not theirs
    always_ff @(posedge wb_clk_i) begin
        if (first) begin
            wb_dat_o <= (mode_rdata_i | mb_rdata_i) & lane_mask;
        end
    end

endmodule

`default_nettype wire

// File: can_mode_ctrl.sv
// control, status and timing registers with the operating-mode FSM, idle counter and prescaler
`timescale 1ns/1ns
`default_nettype none

module can_mode_ctrl #(
    parameter int IDLE_BITS = 11
) (
    input  wire                          wb_clk_i,
    input  wire                          nRST,
    input  can_pkg::bus_req_t            req_i,
    input  wire                          bitstrobe_i,
    input  wire                          curr_sample_i,
    input  wire                          rx_busy_i,
    input  wire                          tx_busy_i,
    output logic [can_pkg::DATA_W-1:0]   rdata_o,
    output logic                         can_clk_o,
    output logic                         can_nrst_o,
    output logic                         tx_enable_o,
    output logic [can_pkg::TS_W:0]       ts1_o,
    output logic [can_pkg::TS_W:0]       ts2_o,
    output logic                         tx_priority_o,
    output logic                         auto_retrans_o
);

    localparam int IDLE_W = $clog2(IDLE_BITS + 1);

    can_pkg::mcr_t                 mcr_q;
    can_pkg::tmgr_t                tmgr_q;
    can_pkg::can_mode_e            mode_q, mode_d;
    logic                          en_q, en_d;
    logic [2:0]                    stat_q;  // tx_busy, rx_busy, curr_sample
    logic [IDLE_W-1:0]             idle_cnt_q;
    logic                          bus_idle;
    logic [can_pkg::BRP_W-1:0]     pre_cnt_q;

    ////////////////////////////////////////////////////////////
    // registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge wb_clk_i or negedge nRST) begin
        if (!nRST) begin
            mcr_q  <= '0;
            tmgr_q <= '0;
            stat_q <= '0;
        end else begin
            stat_q <= {tx_busy_i, rx_busy_i, curr_sample_i};
            if (req_i.wr && req_i.idx == can_pkg::idx_mcr) begin
                mcr_q      <= can_pkg::mcr_t'(can_pkg::byte_merge(mcr_q, req_i));
                mcr_q.rsvd <= '0;
            end else begin
                mcr_q.reset <= 1'b0;  // one cycle controller reset
            end
            if (mode_q == can_pkg::mode_sleep) mcr_q.sleep <= 1'b0;
            if (req_i.wr && req_i.idx == can_pkg::idx_tmgr) begin
                tmgr_q      <= can_pkg::tmgr_t'(can_pkg::byte_merge(tmgr_q, req_i));
                tmgr_q.rsvd <= '0;
            end
        end
    end

    always_comb begin
        case (req_i.idx)
            can_pkg::idx_mcr:  rdata_o = mcr_q;
            can_pkg::idx_msr:  rdata_o = {{(can_pkg::DATA_W-5){1'b0}}, stat_q, mode_q};
            can_pkg::idx_tmgr: rdata_o = tmgr_q;
            default:           rdata_o = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // mode FSM and bus idle detection
    ////////////////////////////////////////////////////////////

    assign bus_idle = (idle_cnt_q == IDLE_W'(IDLE_BITS));

    always_ff @(posedge wb_clk_i or negedge nRST) begin
        if (!nRST) begin
            idle_cnt_q <= '0;
        end else if (bitstrobe_i) begin
            if (!curr_sample_i) idle_cnt_q <= '0;  // dominant bit restarts the count
            else if (!bus_idle) idle_cnt_q <= idle_cnt_q + 1'b1;
        end
    end

    always_comb begin
        mode_d = mode_q;
        en_d   = en_q;
        case (mode_q)
            can_pkg::mode_sleep: begin
                if (mcr_q.start) begin
                    mode_d = can_pkg::mode_init;
                    en_d   = 1'b1;
                end
            end
            can_pkg::mode_init: begin
                if (bus_idle) mode_d = can_pkg::mode_normal;
            end
            can_pkg::mode_normal: begin
                if (mcr_q.sleep && !tx_busy_i) begin
                    mode_d = can_pkg::mode_sleep;
                    en_d   = 1'b0;
                end
            end
            default: mode_d = can_pkg::mode_sleep;
        endcase
    end

    always_ff @(posedge wb_clk_i or negedge nRST) begin
        if (!nRST) begin
            mode_q <= can_pkg::mode_sleep;
            en_q   <= 1'b0;
        end else begin
            mode_q <= mode_d;
            en_q   <= en_d;
        end
    end

    // can clock strobe, one pulse every brp+1 cycles
    always_ff @(posedge wb_clk_i or negedge nRST) begin
        if (!nRST) begin
            pre_cnt_q <= '0;
            can_clk_o <= 1'b0;
        end else if (!en_q) begin
            pre_cnt_q <= '0;
            can_clk_o <= 1'b0;
        end else if (pre_cnt_q >= tmgr_q.brp) begin
            pre_cnt_q <= '0;
            can_clk_o <= 1'b1;
        end else begin
            pre_cnt_q <= pre_cnt_q + 1'b1;
            can_clk_o <= 1'b0;
        end
    end

    assign can_nrst_o     = ~mcr_q.reset;
    assign tx_enable_o    = (mode_q == can_pkg::mode_normal);
    assign ts1_o          = {1'b0, tmgr_q.ts1} + 1'b1;
    assign ts2_o          = {1'b0, tmgr_q.ts2} + 1'b1;
    assign tx_priority_o  = mcr_q.tx_priority;
    assign auto_retrans_o = mcr_q.auto_retrans;

endmodule

`default_nettype wire

// File: can_tx_mailbox.sv
// transmit mailboxes with arbitration, lock and the registered frame to the transmit unit
`timescale 1ns/1ns
`default_nettype none

module can_tx_mailbox #(
    parameter int NUM_MB = 3
) (
    input  wire                          wb_clk_i,
    input  wire                          nRST,
    input  can_pkg::bus_req_t            req_i,
    input  wire                          tx_priority_i,
    input  wire                          auto_retrans_i,
    input  wire                          tx_done_i,
    input  wire                          tx_arb_loss_i,
    output logic [can_pkg::DATA_W-1:0]   rdata_o,
    output logic                         tx_pkt_ready_o,
    output can_pkg::tx_frame_t           tx_frame_o
);

    localparam int IDX_W = (NUM_MB > 1) ? $clog2(NUM_MB) : 1;

    can_pkg::mb_id_t            mb_id_q  [NUM_MB];
    logic [can_pkg::DLC_W-1:0]  mb_dlc_q [NUM_MB];
    logic [can_pkg::DATA_W-1:0] mb_dlo_q [NUM_MB];
    logic [can_pkg::DATA_W-1:0] mb_dhi_q [NUM_MB];

    logic [NUM_MB-1:0]          hit_id, hit_sz, hit_dlo, hit_dhi;
    logic                       pick_found;
    logic [IDX_W-1:0]           pick_idx;
    logic [can_pkg::ID_W-1:0]   best_id;
    logic                       lock_q;
    logic [IDX_W-1:0]           sel_q;
    logic                       tx_release;

    // per-mailbox register decode
    always_comb begin
        for (int i = 0; i < NUM_MB; i++) begin
            hit_id[i]  = int'(req_i.idx) == int'(can_pkg::idx_id0) + i;
            hit_sz[i]  = int'(req_i.idx) == int'(can_pkg::idx_size0) + i;
            hit_dlo[i] = int'(req_i.idx) == int'(can_pkg::idx_dlo0) + i;
            hit_dhi[i] = int'(req_i.idx) == int'(can_pkg::idx_dhi0) + i;
        end
    end

    assign tx_release = lock_q & (tx_done_i | (tx_arb_loss_i & ~auto_retrans_i));

    ////////////////////////////////////////////////////////////
    // mailbox registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge wb_clk_i or negedge nRST) begin
        if (!nRST) begin
            mb_id_q <= '{default: '0};
        end else begin
            for (int i = 0; i < NUM_MB; i++) begin
                if (req_i.wr && hit_id[i]) begin
                    mb_id_q[i] <= can_pkg::mb_id_t'(can_pkg::byte_merge(mb_id_q[i], req_i));
                end
            end
            if (tx_release) mb_id_q[sel_q].ready <= 1'b0;  // frame is finished
        end
    end

    always_ff @(posedge wb_clk_i) begin
        for (int i = 0; i < NUM_MB; i++) begin
            if (req_i.wr && hit_sz[i] && req_i.wmask[0]) begin
                mb_dlc_q[i] <= req_i.wdata[can_pkg::DLC_W-1:0];
            end
            if (req_i.wr && hit_dlo[i]) mb_dlo_q[i] <= can_pkg::byte_merge(mb_dlo_q[i], req_i);
            if (req_i.wr && hit_dhi[i]) mb_dhi_q[i] <= can_pkg::byte_merge(mb_dhi_q[i], req_i);
        end
    end

    always_comb begin
        rdata_o = '0;
        for (int i = 0; i < NUM_MB; i++) begin
            if (hit_id[i]) rdata_o = mb_id_q[i];
            if (hit_sz[i]) rdata_o = {{(can_pkg::DATA_W-can_pkg::DLC_W){1'b0}}, mb_dlc_q[i]};
            if (hit_dlo[i]) rdata_o = mb_dlo_q[i];
            if (hit_dhi[i]) rdata_o = mb_dhi_q[i];
        end
    end

    ////////////////////////////////////////////////////////////
    // arbitration and transmit side
    ////////////////////////////////////////////////////////////

    // priority mode takes the first ready box, else the lowest id, ties to the lower box
    always_comb begin
        pick_found = 1'b0;
        pick_idx   = '0;
        best_id    = '0;
        for (int i = 0; i < NUM_MB; i++) begin
            if (mb_id_q[i].ready) begin
                if (!pick_found || (!tx_priority_i && mb_id_q[i].id < best_id)) begin
                    pick_found = 1'b1;
                    pick_idx   = IDX_W'(i);
                    best_id    = mb_id_q[i].id;
                end
            end
        end
    end

    always_ff @(posedge wb_clk_i or negedge nRST) begin
        if (!nRST) begin
            lock_q <= 1'b0;
            sel_q  <= '0;
        end else if (tx_release) begin
            lock_q <= 1'b0;
        end else if (!lock_q && pick_found) begin
            lock_q <= 1'b1;
            sel_q  <= pick_idx;
        end
    end

    // frame only loads while unlocked, so it holds through the transmission
    always_ff @(posedge wb_clk_i) begin
        if (!lock_q && pick_found) begin
            tx_frame_o.id   <= mb_id_q[pick_idx].id;
            tx_frame_o.dlc  <= mb_dlc_q[pick_idx];
            tx_frame_o.rtr  <= mb_id_q[pick_idx].rtr;
            tx_frame_o.ext  <= mb_id_q[pick_idx].ext;
            tx_frame_o.data <= {mb_dhi_q[pick_idx], mb_dlo_q[pick_idx]};
        end
    end

    assign tx_pkt_ready_o = lock_q;

endmodule

`default_nettype wire

// File: can_wb_top.sv
// top level of the CAN wishbone register slave, connects port, mode control and mailboxes
`timescale 1ns/1ns
`default_nettype none

module can_wb_top (
    input  wire                          wb_clk_i,
    input  wire                          nRST,
    input  wire [can_pkg::DATA_W-1:0]    wb_adr_i,
    input  wire [can_pkg::DATA_W-1:0]    wb_dat_i,
    input  wire [can_pkg::SEL_W-1:0]     wb_sel_i,
    input  wire                          wb_we_i,
    input  wire                          wb_cyc_i,
    input  wire                          wb_stb_i,
    output logic                         wb_ack_o,
    output logic [can_pkg::DATA_W-1:0]   wb_dat_o,
    input  wire                          bitstrobe_i,
    input  wire                          curr_sample_i,
    input  wire                          rx_busy_i,
    input  wire                          tx_busy_i,
    input  wire                          tx_done_i,
    input  wire                          tx_arb_loss_i,
    output logic                         can_clk_o,
    output logic                         can_nrst_o,
    output logic                         tx_enable_o,
    output logic [can_pkg::TS_W:0]       ts1_o,
    output logic [can_pkg::TS_W:0]       ts2_o,
    output logic                         tx_pkt_ready_o,
    output can_pkg::tx_frame_t           tx_frame_o
);

    can_pkg::bus_req_t          req;
    logic [can_pkg::DATA_W-1:0] mode_rdata;
    logic [can_pkg::DATA_W-1:0] mb_rdata;
    logic                       tx_priority;
    logic                       auto_retrans;

    can_wb_port u_port (
        .wb_clk_i     (wb_clk_i),
        .nRST         (nRST),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .wb_sel_i     (wb_sel_i),
        .wb_we_i      (wb_we_i),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .mode_rdata_i (mode_rdata),
        .mb_rdata_i   (mb_rdata),
        .wb_ack_o     (wb_ack_o),
        .wb_dat_o     (wb_dat_o),
        .req_o        (req)
    );

    can_mode_ctrl #(
        .IDLE_BITS (can_pkg::IDLE_BITS)
    ) u_mode (
        .wb_clk_i       (wb_clk_i),
        .nRST           (nRST),
        .req_i          (req),
        .bitstrobe_i    (bitstrobe_i),
        .curr_sample_i  (curr_sample_i),
        .rx_busy_i      (rx_busy_i),
        .tx_busy_i      (tx_busy_i),
        .rdata_o        (mode_rdata),
        .can_clk_o      (can_clk_o),
        .can_nrst_o     (can_nrst_o),
        .tx_enable_o    (tx_enable_o),
        .ts1_o          (ts1_o),
        .ts2_o          (ts2_o),
        .tx_priority_o  (tx_priority),
        .auto_retrans_o (auto_retrans)
    );

    can_tx_mailbox #(
        .NUM_MB (can_pkg::NUM_MB)
    ) u_mailbox (
        .wb_clk_i       (wb_clk_i),
        .nRST           (nRST),
        .req_i          (req),
        .tx_priority_i  (tx_priority),
        .auto_retrans_i (auto_retrans),
        .tx_done_i      (tx_done_i),
        .tx_arb_loss_i  (tx_arb_loss_i),
        .rdata_o        (mb_rdata),
        .tx_pkt_ready_o (tx_pkt_ready_o),
        .tx_frame_o     (tx_frame_o)
    );

endmodule

`default_nettype wire

// File: can_wb_chk.sv
// protocol assertions bound into the CAN wishbone top level, fail through $error only
`timescale 1ns/1ns
`default_nettype none

module can_wb_chk (
    input wire                wb_clk_i,
    input wire                nRST,
    input wire                wb_cyc_i,
    input wire                wb_stb_i,
    input wire                wb_ack_o,
    input wire                tx_pkt_ready_o,
    input can_pkg::tx_frame_t tx_frame_o,
    input wire                can_clk_o
);

    ack_in_access: assert property (@(posedge wb_clk_i) disable iff (!nRST)
        wb_ack_o |-> (wb_cyc_i && wb_stb_i))
        else $error("wb_ack_o high outside a strobe cycle");

    // frame may only change while the mailbox is unlocked
    frame_stable: assert property (@(posedge wb_clk_i) disable iff (!nRST)
        (tx_pkt_ready_o && $past(tx_pkt_ready_o)) |-> $stable(tx_frame_o))
        else $error("tx_frame_o changed while tx_pkt_ready_o held");

    can_clk_single: assert property (@(posedge wb_clk_i) disable iff (!nRST)
        can_clk_o |=> !can_clk_o)
        else $error("can_clk_o high for two cycles");

endmodule

bind can_wb_top can_wb_chk u_chk (
    .wb_clk_i       (wb_clk_i),
    .nRST           (nRST),
    .wb_cyc_i       (wb_cyc_i),
    .wb_stb_i       (wb_stb_i),
    .wb_ack_o       (wb_ack_o),
    .tx_pkt_ready_o (tx_pkt_ready_o),
    .tx_frame_o     (tx_frame_o),
    .can_clk_o      (can_clk_o)
);

`default_nettype wire

// File: can_wb_tb.sv
// testbench for the CAN wishbone slave, replays the operations of can_wb_stim.txt against the DUT
`timescale 1ns/1ns
`default_nettype none

module can_wb_tb;

    localparam int TIMEOUT = 100;  // cycles per wait

    logic                        wb_clk_i;
    logic                        nRST;
    logic [can_pkg::DATA_W-1:0]  wb_adr_i;
    logic [can_pkg::DATA_W-1:0]  wb_dat_i;
    logic [can_pkg::SEL_W-1:0]   wb_sel_i;
    logic                        wb_we_i;
    logic                        wb_cyc_i;
    logic                        wb_stb_i;
    logic                        wb_ack_o;
    logic [can_pkg::DATA_W-1:0]  wb_dat_o;
    logic                        bitstrobe_i;
    logic                        curr_sample_i;
    logic                        rx_busy_i;
    logic                        tx_busy_i;
    logic                        tx_done_i;
    logic                        tx_arb_loss_i;
    logic                        can_clk_o;
    logic                        can_nrst_o;
    logic                        tx_enable_o;
    logic [can_pkg::TS_W:0]      ts1_o;
    logic [can_pkg::TS_W:0]      ts2_o;
    logic                        tx_pkt_ready_o;
    can_pkg::tx_frame_t          tx_frame_o;
    int                          nrst_low;  // cycles seen with can_nrst_o low
    int                          nrst_exp;

    can_wb_top UUT (.*);

    initial begin
        wb_clk_i = 1'b0;
        forever #10 wb_clk_i = ~wb_clk_i;
    end

    // controller reset output, sampled mid cycle
    always @(negedge wb_clk_i) begin
        if (nRST && !can_nrst_o) nrst_low++;
    end

    ////////////////////////////////////////////////////////////
    // failure handling and checks
    ////////////////////////////////////////////////////////////

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // bus and side-signal tasks
    ////////////////////////////////////////////////////////////

    // one access, stb held until ack, then dropped for at least a cycle
    task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                              input logic [3:0] sel, output logic [31:0] rdata);
        int n;
        @(posedge wb_clk_i);
        #2;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = dat;
        wb_sel_i = sel;
        n = 0;
        do begin
            @(negedge wb_clk_i);
            n++;
            if (n > TIMEOUT) abort_run("timeout waiting for wb_ack_o");
        end while (!wb_ack_o);
        rdata = wb_dat_o;
        @(posedge wb_clk_i);
        #2;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic wait_tx_ready();
        int n;
        n = 0;
        do begin
            @(negedge wb_clk_i);
            n++;
            if (n > TIMEOUT) abort_run("timeout waiting for tx_pkt_ready_o");
        end while (!tx_pkt_ready_o);
    endtask

    // one-cycle done or arbitration-loss pulse from the transmit unit
    task automatic pulse_tx(input logic is_done, input logic exp_ready);
        @(posedge wb_clk_i);
        #2;
        tx_done_i     = is_done;
        tx_arb_loss_i = ~is_done;
        @(posedge wb_clk_i);
        #2;
        tx_done_i     = 1'b0;
        tx_arb_loss_i = 1'b0;
        @(negedge wb_clk_i);
        check("tx_pkt_ready_o", tx_pkt_ready_o, exp_ready);
    endtask

    task automatic pulse_bitstrobe(input int count);
        @(posedge wb_clk_i);
        #2;
        bitstrobe_i = 1'b1;
        repeat (count) @(posedge wb_clk_i);
        #2;
        bitstrobe_i = 1'b0;
        @(posedge wb_clk_i);  // mode register follows one cycle later
        @(negedge wb_clk_i);
    endtask

    // cycles from one can_clk_o pulse to the next
    task automatic measure_can_clk(output int period);
        int n;
        n = 0;
        do begin
            @(negedge wb_clk_i);
            n++;
            if (n > TIMEOUT) abort_run("timeout waiting for a can_clk_o pulse");
        end while (!can_clk_o);
        period = 0;
        do begin
            @(negedge wb_clk_i);
            period++;
            if (period > TIMEOUT) abort_run("timeout waiting for the next can_clk_o pulse");
        end while (!can_clk_o);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int          fd;
        int          code;
        int          period;
        string       line;
        logic [63:0] op;
        logic [31:0] adr, dat, sel, exp, rdata;
        nrst_low      = 0;
        nrst_exp      = 0;
        nRST          = 1'b0;
        wb_adr_i      = '0;
        wb_dat_i      = '0;
        wb_sel_i      = '0;
        wb_we_i       = 1'b0;
        wb_cyc_i      = 1'b0;
        wb_stb_i      = 1'b0;
        bitstrobe_i   = 1'b0;
        curr_sample_i = 1'b0;
        rx_busy_i     = 1'b0;
        tx_busy_i     = 1'b0;
        tx_done_i     = 1'b0;
        tx_arb_loss_i = 1'b0;
        repeat (2) @(posedge wb_clk_i);
        #2;
        nRST = 1'b1;

        fd = $fopen("can_wb_stim.txt", "r");
        if (fd == 0) abort_run("cannot open can_wb_stim.txt");
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            // comment and blank lines do not scan five fields
            if (code != 0 && $sscanf(line, "%s %h %h %h %h", op, adr, dat, sel, exp) == 5) begin
                case (op)
                    "wr": begin
                        bus_access(1'b1, adr, dat, sel[3:0], rdata);
                        // mcr reset bit holds can_nrst_o low for one cycle
                        if (adr[5:2] == 4'd0 && sel[0] && dat[1]) nrst_exp++;
                    end
                    "rd": begin
                        bus_access(1'b0, adr, 32'h0, sel[3:0], rdata);
                        check("wb_dat_o", rdata, exp);
                    end
                    "side": begin
                        @(posedge wb_clk_i);
                        #2;
                        {tx_busy_i, rx_busy_i, curr_sample_i} = dat[2:0];
                    end
                    "bits": begin
                        pulse_bitstrobe(dat);
                        check("tx_enable_o", tx_enable_o, exp);
                    end
                    "clk": begin
                        measure_can_clk(period);
                        check("can_clk_o period", period, exp);
                        check("{ts2_o, ts1_o}", {ts2_o, ts1_o}, dat);
                    end
                    "rdy": begin
                        wait_tx_ready();
                        // expected column is the id word without its ready bit
                        check("{tx_frame_o.ext, tx_frame_o.rtr, tx_frame_o.id}",
                              {tx_frame_o.ext, tx_frame_o.rtr, tx_frame_o.id}, exp[30:0]);
                        check("tx_frame_o.dlc", tx_frame_o.dlc, sel);
                        check("tx_frame_o.data[31:0]", tx_frame_o.data[31:0], dat);
                    end
                    "done": pulse_tx(1'b1, exp[0]);
                    "loss": pulse_tx(1'b0, exp[0]);
                    default: abort_run($sformatf("unknown opcode in stimulus file: %s", op));
                endcase
            end
        end
        $fclose(fd);

        check("can_nrst_o low cycles", nrst_low, nrst_exp);
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: can_wb_stim.txt
# columns: op addr data sel expected, numbers in hex
# rd compares wb_dat_o, rdy checks frame id=expected dlc=sel data_lo=data
wr   08 FFFFFF03 1 0
rd   08 0        F 00000003
wr   08 FFFF54FF 2 0
rd   08 0        2 00005400
wr   08 FFFF5403 F 0
rd   08 0        F 00005403
wr   00 FFFFFFF8 1 0
wr   00 0000FF00 2 0
rd   00 0        F 00000018
rd   3C 0        F 00000000
side 0  1        0 0
wr   00 00000001 1 0
rd   04 0        F 00000005
bits 0  A        0 0
bits 0  1        0 1
rd   04 0        F 00000006
clk  0  36       0 4
side 0  5        0 0
wr   00 00000004 1 0
rd   04 0        F 00000016
side 0  1        0 0
rd   04 0        F 00000004
wr   24 A0A0A0A0 F 0
wr   28 B1B1B1B1 F 0
wr   2C C2C2C2C2 F 0
wr   18 00000008 1 0
wr   1C 00000004 1 0
wr   20 00000002 1 0
wr   10 80000100 F 0
wr   0C 80000300 F 0
wr   14 80000200 F 0
rdy  0  B1B1B1B1 4 00000100
done 0  0        0 0
rdy  0  C2C2C2C2 2 00000200
done 0  0        0 0
rdy  0  A0A0A0A0 8 00000300
done 0  0        0 0
rd   0C 0        F 00000300
rd   10 0        F 00000100
rd   14 0        F 00000200
wr   00 00000008 1 0
wr   14 80000000 8 0
wr   0C 80000000 8 0
wr   10 80000000 8 0
rdy  0  C2C2C2C2 2 00000200
loss 0  0        0 0
rdy  0  A0A0A0A0 8 00000300
wr   00 00000018 1 0
loss 0  0        0 1
done 0  0        0 0
rdy  0  B1B1B1B1 4 00000100
done 0  0        0 0
rd   14 0        F 00000200

// File: can_wb.f
can_pkg.sv
can_wb_port.sv
can_mode_ctrl.sv
can_tx_mailbox.sv
can_wb_top.sv
can_wb_chk.sv
can_wb_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the testbench with Verilator, the result is taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module can_wb_tb -f can_wb.f \
    -o can_wb_sim > sim.log 2>&1 \
    && ./obj_dir/can_wb_sim >> sim.log 2>&1 \
    || echo "Simulation failed" >> sim.log
if grep -q "Simulation failed" sim.log; then
    echo "FAIL (see sim.log)"
    exit 1
fi
echo "PASS"
